/* common/riscv_isa_pkg.sv */
//////////////////////////////////////////////////////////////////////
// RISC-V ISA definitions for the load/store back end
// Data widths, opcodes, load/store funct3 codes and exception causes
//////////////////////////////////////////////////////////////////////

package riscv_isa_pkg;

  // Machine word width, fixed for this core
  localparam int unsigned XLEN  = 32;
  localparam int unsigned EXC_W = 16;

  // Meaningful vector widths
  typedef logic [XLEN-1:0]  xlen_t;
  typedef logic [31:0]      instr_t;
  typedef logic [4:0]       reg_addr_t;
  typedef logic [EXC_W-1:0] exception_t;

  //////////////////////////////////////////////////////////////////////
  // Exception cause bit positions
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned CAUSE_ILLEGAL_INSTR       = 2;
  localparam int unsigned CAUSE_MISALIGNED_LOAD     = 4;
  localparam int unsigned CAUSE_LOAD_ACCESS_FAULT   = 5;
  localparam int unsigned CAUSE_MISALIGNED_STORE    = 6;
  localparam int unsigned CAUSE_STORE_ACCESS_FAULT  = 7;

  //////////////////////////////////////////////////////////////////////
  // Major opcodes, instr[6:2]
  //////////////////////////////////////////////////////////////////////

  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;

  // Load/store width codes, instr[14:12]
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // addi x0, x0, 0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

  // Reset vector
  localparam xlen_t PC_INIT = 32'h8000_0000;

endpackage

/* common/lsu_pipe_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Load/store pipeline types
// Stage items, memory op kind and APB / data RAM sizing
//////////////////////////////////////////////////////////////////////

package lsu_pipe_pkg;

  // Data RAM size in bytes, anything at or above faults
  localparam int unsigned DMEM_BYTES       = 1024;
  localparam int unsigned DMEM_WORDS       = DMEM_BYTES / 4;
  localparam int unsigned DMEM_IDX_W       = $clog2(DMEM_WORDS);
  localparam int unsigned DMEM_WAIT_STATES = 2;

  // APB byte lanes
  localparam int unsigned STRB_W = riscv_isa_pkg::XLEN / 8;
  typedef logic [STRB_W-1:0] strb_t;

  // Kind of data memory access an item performs
  typedef enum logic [1:0] {
    NONE,
    LOAD,
    STORE
  } mem_op_e;

  // Execute to memory item
  typedef struct packed {
    logic                       valid;
    logic                       bubble;
    riscv_isa_pkg::xlen_t       pc;
    riscv_isa_pkg::instr_t      instr;
    riscv_isa_pkg::xlen_t       result;
    riscv_isa_pkg::xlen_t       store_data;
    riscv_isa_pkg::exception_t  exception;
  } ex_mem_t;

  // Memory to write-back item
  typedef struct packed {
    logic                       valid;
    logic                       bubble;
    riscv_isa_pkg::xlen_t       pc;
    riscv_isa_pkg::instr_t      instr;
    riscv_isa_pkg::xlen_t       result;
    riscv_isa_pkg::xlen_t       addr;
    mem_op_e                    op;
    riscv_isa_pkg::xlen_t       rdata;
    logic                       err;
    logic                       misaligned;
    riscv_isa_pkg::exception_t  exception;
  } mem_wb_t;

  // Committed result and register write
  typedef struct packed {
    logic                       valid;
    riscv_isa_pkg::xlen_t       pc;
    riscv_isa_pkg::instr_t      instr;
    riscv_isa_pkg::reg_addr_t   dst;
    logic                       we;
    riscv_isa_pkg::xlen_t       wdata;
    riscv_isa_pkg::exception_t  exception;
    riscv_isa_pkg::xlen_t       badaddr;
  } wb_commit_t;

endpackage

/* hw/mem_stage/mem_stage.sv */
//////////////////////////////////////////////////////////////////////
// Memory stage
// Takes execute items, checks alignment, runs APB4 data transfers
// and registers one memory/write-back item per accepted item
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lsu_pipe_pkg::ex_mem_t ex_item_i,
  output logic                  ex_ready_o,
  output logic                  psel_o,
  output logic                  penable_o,
  output logic                  pwrite_o,
  output riscv_isa_pkg::xlen_t  paddr_o,
  output riscv_isa_pkg::xlen_t  pwdata_o,
  output lsu_pipe_pkg::strb_t   pstrb_o,
  input  riscv_isa_pkg::xlen_t  prdata_i,
  input  logic                  pready_i,
  input  logic                  pslverr_i,
  output lsu_pipe_pkg::mem_wb_t mem_wb_o
);
  import riscv_isa_pkg::*;
  import lsu_pipe_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_e;

  state_e     state_q;
  logic       hold_q;
  logic       wb_valid_q;
  ex_mem_t    item_q;
  mem_op_e    op_q;
  logic       misaligned_q;
  mem_wb_t    mem_wb_q;

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [1:0] offset;
  mem_op_e    op_d;
  logic       misaligned_d;
  logic       accept;
  logic       done;
  logic       emit;
  strb_t      strb;

  //////////////////////////////////////////////////////////////////////
  // Decode of the incoming item
  //////////////////////////////////////////////////////////////////////

  assign opcode = ex_item_i.instr[6:2];
  assign funct3 = ex_item_i.instr[14:12];
  assign offset = ex_item_i.result[1:0];

  always_comb begin
    // Bubbles and faulted items never touch memory
    op_d = NONE;
    if (!ex_item_i.bubble && (ex_item_i.exception == '0)) begin
      if (opcode == OPC_LOAD) begin
        op_d = LOAD;
      end else if (opcode == OPC_STORE) begin
        op_d = STORE;
      end
    end
    // Halfword needs even, word needs 4-byte alignment
    case (funct3[1:0])
      2'b01:   misaligned_d = offset[0];
      2'b10:   misaligned_d = (offset != 2'b00);
      default: misaligned_d = 1'b0;
    endcase
    misaligned_d = misaligned_d && (op_d != NONE);
  end

  // One item in the stage at a time
  assign ex_ready_o = !hold_q;
  assign accept     = ex_item_i.valid && ex_ready_o;
  assign done       = (state_q == ACCESS) && pready_i;
  // Non-access items leave one cycle after acceptance
  assign emit       = done || (hold_q && (state_q == IDLE));

  //////////////////////////////////////////////////////////////////////
  // APB transfer FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      hold_q     <= 1'b0;
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= emit;
      case (state_q)
        IDLE: begin
          if (accept && (op_d != NONE) && !misaligned_d) begin
            state_q <= SETUP;
          end
        end
        SETUP:   state_q <= ACCESS;
        ACCESS: begin
          if (pready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (accept) begin
        hold_q <= 1'b1;
      end else if (emit) begin
        hold_q <= 1'b0;
      end
    end
  end

  // Held item and its decode
  always_ff @(posedge clk_i) begin
    if (accept) begin
      item_q       <= ex_item_i;
      op_q         <= op_d;
      misaligned_q <= misaligned_d;
    end
  end

  // Byte lane strobe from width and offset
  always_comb begin
    case (item_q.instr[13:12])
      2'b00:   strb = strb_t'(4'b0001 << item_q.result[1:0]);
      2'b01:   strb = strb_t'(4'b0011 << item_q.result[1:0]);
      default: strb = '1;
    endcase
  end

  // Word address, store data moved to its lanes
  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);
  assign pwrite_o  = (op_q == STORE);
  assign paddr_o   = {item_q.result[XLEN-1:2], 2'b00};
  assign pwdata_o  = item_q.store_data << {item_q.result[1:0], 3'b000};
  assign pstrb_o   = pwrite_o ? strb : '0;

  //////////////////////////////////////////////////////////////////////
  // Memory to write-back register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (emit) begin
      mem_wb_q.valid      <= item_q.valid;
      mem_wb_q.bubble     <= item_q.bubble;
      mem_wb_q.pc         <= item_q.pc;
      mem_wb_q.instr      <= item_q.instr;
      mem_wb_q.result     <= item_q.result;
      mem_wb_q.addr       <= item_q.result;
      mem_wb_q.op         <= op_q;
      // Response only meaningful on a completed transfer
      mem_wb_q.rdata      <= (done && (op_q == LOAD)) ? prdata_i : '0;
      mem_wb_q.err        <= done && pslverr_i;
      mem_wb_q.misaligned <= misaligned_q;
      mem_wb_q.exception  <= item_q.exception;
    end
  end

  always_comb begin
    mem_wb_o       = mem_wb_q;
    mem_wb_o.valid = wb_valid_q;
  end

endmodule

/* hw/wb_stage/wb_stage.sv */
//////////////////////////////////////////////////////////////////////
// Write-back stage
// Aligns and extends load data, merges memory faults into the
// exception vector and produces the register file write
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module wb_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  lsu_pipe_pkg::mem_wb_t    mem_wb_i,
  output lsu_pipe_pkg::wb_commit_t commit_o
);
  import riscv_isa_pkg::*;
  import lsu_pipe_pkg::*;

  logic [4:0]  opcode;
  logic [2:0]  funct3;
  reg_addr_t   dst;
  logic [1:0]  offset;
  xlen_t       shifted;
  xlen_t       load_data;
  xlen_t       wdata_d;
  exception_t  exc;
  logic        mem_fault;
  logic        we_d;

  // Control registers
  logic        valid_q;
  logic        we_q;
  xlen_t       pc_q;
  instr_t      instr_q;
  exception_t  exc_q;

  // Payload registers
  reg_addr_t   dst_q;
  xlen_t       wdata_q;
  xlen_t       badaddr_q;

  assign opcode = mem_wb_i.instr[6:2];
  assign funct3 = mem_wb_i.instr[14:12];
  assign dst    = mem_wb_i.instr[11:7];
  assign offset = mem_wb_i.addr[1:0];

  //////////////////////////////////////////////////////////////////////
  // Load data alignment and extension
  //////////////////////////////////////////////////////////////////////

  // Addressed byte down to lane 0
  assign shifted = mem_wb_i.rdata >> {offset, 3'b000};

  always_comb begin
    case (funct3)
      F3_B:    load_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      F3_H:    load_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      F3_BU:   load_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
      F3_HU:   load_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
      // F3_W and anything unsupported
      default: load_data = shifted;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Exceptions
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    exc = mem_wb_i.exception;
    // op is NONE for bubbles and already faulted items
    if (mem_wb_i.op == LOAD) begin
      exc[CAUSE_MISALIGNED_LOAD]   = exc[CAUSE_MISALIGNED_LOAD] | mem_wb_i.misaligned;
      exc[CAUSE_LOAD_ACCESS_FAULT] = exc[CAUSE_LOAD_ACCESS_FAULT] | mem_wb_i.err;
    end
    if (mem_wb_i.op == STORE) begin
      exc[CAUSE_MISALIGNED_STORE]   = exc[CAUSE_MISALIGNED_STORE] | mem_wb_i.misaligned;
      exc[CAUSE_STORE_ACCESS_FAULT] = exc[CAUSE_STORE_ACCESS_FAULT] | mem_wb_i.err;
    end
  end

  // Memory causes report the data address, all others the PC
  assign mem_fault = exc[CAUSE_MISALIGNED_LOAD]  | exc[CAUSE_LOAD_ACCESS_FAULT] |
                     exc[CAUSE_MISALIGNED_STORE] | exc[CAUSE_STORE_ACCESS_FAULT];

  //////////////////////////////////////////////////////////////////////
  // Register file write
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    we_d = mem_wb_i.valid && !mem_wb_i.bubble && (exc == '0) && (dst != '0);
    // No destination for these
    if ((opcode == OPC_STORE) || (opcode == OPC_BRANCH) || (opcode == OPC_MISC_MEM)) begin
      we_d = 1'b0;
    end
  end

  assign wdata_d = (opcode == OPC_LOAD) ? load_data : mem_wb_i.result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
      pc_q    <= PC_INIT;
      instr_q <= INSTR_NOP;
      exc_q   <= '0;
    end else begin
      valid_q <= mem_wb_i.valid;
      we_q    <= we_d;
      if (mem_wb_i.valid) begin
        pc_q    <= mem_wb_i.pc;
        instr_q <= mem_wb_i.instr;
        exc_q   <= exc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_wb_i.valid) begin
      dst_q     <= dst;
      wdata_q   <= wdata_d;
      badaddr_q <= mem_fault ? mem_wb_i.addr : mem_wb_i.pc;
    end
  end

  assign commit_o = '{
    valid:     valid_q,
    pc:        pc_q,
    instr:     instr_q,
    dst:       dst_q,
    we:        we_q,
    wdata:     wdata_q,
    exception: exc_q,
    badaddr:   badaddr_q
  };

endmodule

/* hw/dmem_apb_ram.sv */
//////////////////////////////////////////////////////////////////////
// Data RAM, APB4 slave
// Byte strobed writes, fixed wait states, error above the RAM size
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dmem_apb_ram #(
  parameter int unsigned WAIT_STATES = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  riscv_isa_pkg::xlen_t paddr_i,
  input  riscv_isa_pkg::xlen_t pwdata_i,
  input  lsu_pipe_pkg::strb_t  pstrb_i,
  output riscv_isa_pkg::xlen_t prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o
);
  import riscv_isa_pkg::*;
  import lsu_pipe_pkg::*;

  // Wait counter wide enough for WAIT_STATES, at least one bit
  localparam int unsigned CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  xlen_t                 mem_q [DMEM_WORDS];
  logic [CNT_W-1:0]      wait_cnt_q;
  logic [DMEM_IDX_W-1:0] idx;
  logic                  access;
  logic                  out_of_range;

  assign access       = psel_i && penable_i;
  assign out_of_range = (paddr_i >= XLEN'(DMEM_BYTES));
  assign idx          = paddr_i[DMEM_IDX_W+1:2];

  // Ready after WAIT_STATES low cycles of ACCESS
  assign pready_o  = access && (wait_cnt_q == CNT_W'(WAIT_STATES));
  assign pslverr_o = pready_o && out_of_range;
  assign prdata_o  = (pready_o && !out_of_range) ? mem_q[idx] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_cnt_q <= '0;
    end else if (!access || pready_o) begin
      wait_cnt_q <= '0;
    end else begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  // Strobed byte write on completion
  always_ff @(posedge clk_i) begin
    if (pready_o && pwrite_i && !out_of_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (pstrb_i[b]) begin
          mem_q[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

/* hw/lsu_pipe_top.sv */
//////////////////////////////////////////////////////////////////////
// Load/store back end top level
// Memory stage, APB data RAM and write-back stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_pipe_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  lsu_pipe_pkg::ex_mem_t     ex_item_i,
  output logic                      ex_ready_o,
  output lsu_pipe_pkg::wb_commit_t  commit_o,
  output logic                      rf_we_o,
  output riscv_isa_pkg::reg_addr_t  rf_dst_o,
  output riscv_isa_pkg::xlen_t      rf_wdata_o
);
  import riscv_isa_pkg::*;
  import lsu_pipe_pkg::*;

  // APB bus
  logic    psel;
  logic    penable;
  logic    pwrite;
  xlen_t   paddr;
  xlen_t   pwdata;
  strb_t   pstrb;
  xlen_t   prdata;
  logic    pready;
  logic    pslverr;

  mem_wb_t mem_wb;

  mem_stage u_mem_stage (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ex_item_i  (ex_item_i),
    .ex_ready_o (ex_ready_o),
    .psel_o     (psel),
    .penable_o  (penable),
    .pwrite_o   (pwrite),
    .paddr_o    (paddr),
    .pwdata_o   (pwdata),
    .pstrb_o    (pstrb),
    .prdata_i   (prdata),
    .pready_i   (pready),
    .pslverr_i  (pslverr),
    .mem_wb_o   (mem_wb)
  );

  dmem_apb_ram #(
    .WAIT_STATES (DMEM_WAIT_STATES)
  ) u_dmem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  wb_stage u_wb_stage (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .mem_wb_i (mem_wb),
    .commit_o (commit_o)
  );

  // Register file write port
  assign rf_we_o    = commit_o.we;
  assign rf_dst_o   = commit_o.dst;
  assign rf_wdata_o = commit_o.wdata;

endmodule

/* bench/lsu_pipe_assertions.sv */
//////////////////////////////////////////////////////////////////////
// Load/store back end assertions
// APB protocol, reset state and write port checks on the top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_pipe_assertions (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     psel,
  input logic                     penable,
  input logic                     pwrite,
  input riscv_isa_pkg::xlen_t     paddr,
  input riscv_isa_pkg::xlen_t     pwdata,
  input lsu_pipe_pkg::strb_t      pstrb,
  input logic                     pready,
  input logic                     ex_ready_o,
  input lsu_pipe_pkg::wb_commit_t commit_o,
  input logic                     rf_we_o
);

  // Request held from SETUP until the completing ACCESS cycle
  apb_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel && !(penable && pready) |=> psel && $stable(paddr) && $stable(pwrite) &&
                                     $stable(pwdata) && $stable(pstrb))
    else $error("APB request changed before the transfer completed");

  // ACCESS only straight after a SETUP cycle
  setup_first_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(penable) |-> psel && $past(psel && !penable))
    else $error("penable rose without a preceding SETUP cycle");

  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> !commit_o.valid && !rf_we_o)
    else $error("Commit or register write active during reset");

  we_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_we_o |-> commit_o.valid)
    else $error("Register write without a valid commit");

  // Memory stage busy for the whole transfer
  busy_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel |-> !ex_ready_o)
    else $error("ex_ready_o high during an APB transfer");

endmodule

bind lsu_pipe_top lsu_pipe_assertions u_assertions (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .paddr      (paddr),
  .pwdata     (pwdata),
  .pstrb      (pstrb),
  .pready     (pready),
  .ex_ready_o (ex_ready_o),
  .commit_o   (commit_o),
  .rf_we_o    (rf_we_o)
);

/* bench/lsu_pipe_tb.sv */
//////////////////////////////////////////////////////////////////////
// Load/store back end testbench
// Seeded random execute items checked against a RAM and commit model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_pipe_tb;
  import riscv_isa_pkg::*;
  import lsu_pipe_pkg::*;

  localparam int unsigned SEED          = 71131;
  localparam int          NUM_ITEMS     = 300;
  localparam int          READY_TIMEOUT = 64;
  localparam int          DRAIN_TIMEOUT = 200;
  // SETUP, WAIT_STATES low ACCESS cycles, completing ACCESS, mem_wb, commit
  localparam int          MEM_LATENCY   = 3 + DMEM_WAIT_STATES;

  logic       clk_i;
  logic       rst_ni;
  ex_mem_t    ex_item_i;
  logic       ex_ready_o;
  wb_commit_t commit_o;
  logic       rf_we_o;
  reg_addr_t  rf_dst_o;
  xlen_t      rf_wdata_o;

  // Reference RAM and expected commits in issue order
  logic [7:0] ref_mem [DMEM_BYTES];
  wb_commit_t exp_q [$];
  int         due_q [$];
  int         cycle_cnt;
  int         n_issued;
  int         n_committed;
  xlen_t      pc_next;
  ex_mem_t    item;

  lsu_pipe_top DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ex_item_i  (ex_item_i),
    .ex_ready_o (ex_ready_o),
    .commit_o   (commit_o),
    .rf_we_o    (rf_we_o),
    .rf_dst_o   (rf_dst_o),
    .rf_wdata_o (rf_wdata_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  // Control fields only, payload fields have their own checks
  task automatic check_commit(input string name, input wb_commit_t got, input wb_commit_t exp);
    wb_commit_t g;
    wb_commit_t e;
    g = got;
    e = exp;
    g.wdata     = '0;
    e.wdata     = '0;
    g.exception = '0;
    e.exception = '0;
    g.badaddr   = '0;
    e.badaddr   = '0;
    if (g !== e) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run("Commit control fields differ from the model");
    end
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run("Value differs from the model");
    end
  endtask

  task automatic check_exc(input string name, input exception_t got, input exception_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run("Exception vector differs from the model");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Little-endian bytes from the model, then extension by width code
  function automatic xlen_t load_value(input xlen_t addr, input logic [2:0] f3);
    logic [7:0] b [4];
    int         base;
    base = int'(addr % DMEM_BYTES);
    for (int i = 0; i < 4; i++) begin
      b[i] = ref_mem[(base + i) % DMEM_BYTES];
    end
    case (f3)
      F3_B:    return {{24{b[0][7]}}, b[0]};
      F3_BU:   return {24'h0, b[0]};
      F3_H:    return {{16{b[1][7]}}, b[1], b[0]};
      F3_HU:   return {16'h0, b[1], b[0]};
      default: return {b[3], b[2], b[1], b[0]};
    endcase
  endfunction

  task automatic expect_item(input ex_mem_t it, output wb_commit_t exp, output int lat);
    logic [4:0] opc;
    logic [2:0] f3;
    xlen_t      addr;
    int         size;
    logic       is_load;
    logic       is_store;
    logic       mem_item;
    logic       mis;
    logic       oor;
    exception_t exc;
    opc      = it.instr[6:2];
    f3       = it.instr[14:12];
    addr     = it.result;
    size     = 1 << f3[1:0];
    is_load  = (opc == OPC_LOAD);
    is_store = (opc == OPC_STORE);
    // Only live, fault-free loads and stores reach memory
    mem_item = (is_load || is_store) && !it.bubble && (it.exception == '0);
    mis      = mem_item && ((addr & xlen_t'(size - 1)) != '0);
    oor      = mem_item && !mis && (addr >= xlen_t'(DMEM_BYTES));
    exc      = it.exception;
    if (mis) exc[is_load ? CAUSE_MISALIGNED_LOAD : CAUSE_MISALIGNED_STORE] = 1'b1;
    if (oor) exc[is_load ? CAUSE_LOAD_ACCESS_FAULT : CAUSE_STORE_ACCESS_FAULT] = 1'b1;
    exp           = '0;
    exp.valid     = 1'b1;
    exp.pc        = it.pc;
    exp.instr     = it.instr;
    exp.dst       = it.instr[11:7];
    exp.exception = exc;
    exp.badaddr   = (mis || oor) ? addr : it.pc;
    exp.we        = !it.bubble && (exc == '0) && (exp.dst != '0) &&
                    !(is_store || (opc == OPC_BRANCH) || (opc == OPC_MISC_MEM));
    exp.wdata     = it.result;
    if (is_load && mem_item && !mis && !oor) exp.wdata = load_value(addr, f3);
    if (is_store && mem_item && !mis && !oor) begin
      for (int i = 0; i < size; i++) begin
        ref_mem[int'(addr) + i] = it.store_data[8*i +: 8];
      end
    end
    lat = (mem_item && !mis) ? MEM_LATENCY : 2;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic make_item(output ex_mem_t it);
    int         kind;
    int         r;
    int         size;
    logic [4:0] opc;
    logic [2:0] f3;
    it            = '0;
    it.valid      = 1'b1;
    it.pc         = pc_next;
    pc_next       = pc_next + 4;
    it.instr      = $urandom;
    it.result     = $urandom;
    it.store_data = $urandom;
    f3            = it.instr[14:12];
    kind          = $urandom_range(0, 99);
    if (kind < 25) begin
      opc = ($urandom_range(0, 1) == 0) ? OPC_OP_IMM : OPC_OP;
    end else if (kind < 31) begin
      opc = OPC_BRANCH;
    end else if (kind < 35) begin
      opc = OPC_MISC_MEM;
    end else if (kind < 68) begin
      opc = OPC_LOAD;
      case ($urandom_range(0, 4))
        0:       f3 = F3_B;
        1:       f3 = F3_H;
        2:       f3 = F3_W;
        3:       f3 = F3_BU;
        default: f3 = F3_HU;
      endcase
    end else begin
      opc = OPC_STORE;
      case ($urandom_range(0, 2))
        0:       f3 = F3_B;
        1:       f3 = F3_H;
        default: f3 = F3_W;
      endcase
    end
    // Address: 1 in 10 out of range, 1 in 10 misaligned
    if ((opc == OPC_LOAD) || (opc == OPC_STORE)) begin
      size = 1 << f3[1:0];
      r    = $urandom_range(0, 9);
      if (r == 0) it.result = xlen_t'(DMEM_BYTES) + ($urandom_range(0, 4095) << 2);
      else it.result = $urandom_range(0, DMEM_BYTES / 4 - 1) << 2;
      if ((r == 1) && (size == 2)) it.result[1:0] = 2'(2 * $urandom_range(0, 1) + 1);
      else if ((r == 1) && (size == 4)) it.result[1:0] = 2'($urandom_range(1, 3));
      else it.result[1:0] = 2'($urandom_range(0, 4 / size - 1) * size);
    end
    it.instr[6:0]   = {opc, 2'b11};
    it.instr[14:12] = f3;
    if ($urandom_range(0, 7) == 0) it.instr[11:7] = '0;
    r = $urandom_range(0, 99);
    if (r < 6) it.bubble = 1'b1;
    else if (r < 13) it.exception[CAUSE_ILLEGAL_INSTR] = 1'b1;
  endtask

  // Hold the item until accepted, then queue its expected commit
  task automatic drive_item(input ex_mem_t it);
    wb_commit_t exp;
    int         lat;
    int         waited;
    expect_item(it, exp, lat);
    ex_item_i = it;
    waited    = 0;
    while (!ex_ready_o) begin
      if (waited == READY_TIMEOUT) abort_run("Timeout waiting for ex_ready_o");
      @(posedge clk_i);
      #1;
      waited++;
    end
    @(posedge clk_i);
    #1;
    exp_q.push_back(exp);
    due_q.push_back(cycle_cnt + lat);
    n_issued++;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == DRAIN_TIMEOUT) abort_run("Timeout waiting for the last commits");
      @(posedge clk_i);
      waited++;
    end
    // Room for any stray commit to show up
    repeat (4) @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Commit monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : commit_monitor
    wb_commit_t exp;
    int         due;
    if (rst_ni && commit_o.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("Commit seen with no item outstanding");
      end else begin
        exp = exp_q.pop_front();
        due = due_q.pop_front();
        n_committed++;
        check_commit("commit_o", commit_o, exp);
        check_exc("commit_o.exception", commit_o.exception, exp.exception);
        check_word("commit_o.badaddr", commit_o.badaddr, exp.badaddr);
        check_word("commit cycle", xlen_t'(cycle_cnt), xlen_t'(due));
        check_word("rf_we_o", xlen_t'(rf_we_o), xlen_t'(exp.we));
        check_word("rf_dst_o", xlen_t'(rf_dst_o), xlen_t'(exp.dst));
        if (exp.we) begin
          check_word("commit_o.wdata", commit_o.wdata, exp.wdata);
          check_word("rf_wdata_o", rf_wdata_o, exp.wdata);
        end
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    clk_i       = 1'b0;
    rst_ni      = 1'b1;
    ex_item_i   = '0;
    cycle_cnt   = 0;
    n_issued    = 0;
    n_committed = 0;
    pc_next     = PC_INIT;
    #1;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    check_word("commit_o.valid in reset", xlen_t'(commit_o.valid), '0);
    check_word("rf_we_o in reset", xlen_t'(rf_we_o), '0);
    check_word("ex_ready_o in reset", xlen_t'(ex_ready_o), xlen_t'(1));
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    check_word("ex_ready_o after reset", xlen_t'(ex_ready_o), xlen_t'(1));
    // Known contents in every RAM word, one SW each
    for (int w = 0; w < DMEM_WORDS; w++) begin
      item            = '0;
      item.valid      = 1'b1;
      item.pc         = pc_next;
      pc_next         = pc_next + 4;
      item.instr      = {7'h00, 5'($urandom), 5'($urandom), F3_W, 5'h00, OPC_STORE, 2'b11};
      item.result     = xlen_t'(w) << 2;
      item.store_data = $urandom;
      drive_item(item);
    end
    for (int n = 0; n < NUM_ITEMS; n++) begin
      make_item(item);
      drive_item(item);
    end
    ex_item_i = '0;
    wait_drain();
    $display("%0d items issued, %0d committed", n_issued, n_committed);
    // Stage released once the last item has left
    check_word("ex_ready_o after drain", xlen_t'(ex_ready_o), xlen_t'(1));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* lsu_pipe.f */
common/riscv_isa_pkg.sv
common/lsu_pipe_pkg.sv
hw/mem_stage/mem_stage.sv
hw/wb_stage/wb_stage.sv
hw/dmem_apb_ram.sv
hw/lsu_pipe_top.sv
bench/lsu_pipe_assertions.sv
bench/lsu_pipe_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := lsu_pipe_tb
FILELIST   := lsu_pipe.f
COMMON     := --timing -Wno-fatal
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert $(COMMON)
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
